//--- logic/icache_macros.svh
//================================================
// Widths, line geometry and burst length of the
// instruction-fetch cache
//================================================

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Fetch address counts 4-bit codes
`define FETCH_ADDR_W 16

// Bus side is byte addressed
`define BUS_ADDR_W   16
`define CODE_W       4
`define BYTE_W       8

// One line is 8 codes, filled by a 4-beat burst
`define LINE_CODES   8
`define LINE_BYTES   4

// Returned outside a data phase
`define NOP_CODE     4'hf

`endif

//--- logic/icache_pkg.sv
//================================================
// Shared types of the instruction-fetch cache
//================================================

`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    typedef logic [`FETCH_ADDR_W-1:0]                      fetch_addr_t;
    typedef logic [`BUS_ADDR_W-1:0]                        bus_addr_t;
    typedef logic [$clog2(`LINE_CODES)-1:0]                offset_t;
    typedef logic [`FETCH_ADDR_W-$clog2(`LINE_CODES)-1:0]  tag_t;
    typedef logic [`CODE_W-1:0]                            code_t;
    typedef logic [`BYTE_W-1:0]                            bus_byte_t;
    // Code k sits in bits 4k+3 down to 4k
    typedef logic [`LINE_CODES*`CODE_W-1:0]                line_t;
    typedef logic [$clog2(`LINE_BYTES)-1:0]                beat_t;

endpackage

`default_nettype wire

//--- logic/icache_lookup.sv
//================================================
// Address-phase lookup: tag, valid bit, hit test
// and the data-phase registers
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic        CLK,
    input  logic        RES,
    // Fetch address phase
    input  logic        if_req,
    input  fetch_addr_t if_addr,
    input  logic        slot,
    // Toward the burst sequencer
    output logic        miss_req,
    output tag_t        miss_tag,
    // Toward the line store
    output logic        dphase_hit,
    output logic        dphase_miss,
    output offset_t     dphase_offset,
    output logic        line_we
);

    //================================================
    // Single-entry tag array
    //================================================
    tag_t    tag_q;
    logic    valid_q;
    tag_t    req_tag;
    offset_t req_offset;
    logic    hit;

    // Split the code address into tag and offset
    assign req_tag    = if_addr[`FETCH_ADDR_W-1:$bits(offset_t)];
    assign req_offset = if_addr[$bits(offset_t)-1:0];

    assign hit      = if_req & valid_q & (tag_q == req_tag);
    assign miss_req = if_req & ~hit;
    assign miss_tag = req_tag;

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            valid_q <= 1'b0;
        else if (miss_req & slot)
            valid_q <= 1'b1;
    end

    // Tag follows the miss at acceptance, line data arrives later
    always_ff @(posedge CLK)
    begin
        if (miss_req & slot)
            tag_q <= req_tag;
    end

    //================================================
    // Data-phase state
    //================================================
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            dphase_hit  <= 1'b0;
            dphase_miss <= 1'b0;
        end
        else if (slot)
        begin
            dphase_hit  <= hit;
            dphase_miss <= miss_req;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (slot)
            dphase_offset <= req_offset;
    end

    // Store the filled line when the miss data phase ends
    assign line_we = dphase_miss & slot;

endmodule

`default_nettype wire

//--- logic/bus_burst_fill.sv
//================================================
// Bus burst sequencer: 4 byte beats per miss,
// line assembly and the fetch slot
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module bus_burst_fill
    import icache_pkg::*;
(
    input  logic      CLK,
    input  logic      RES,
    // Miss request from the lookup stage
    input  logic      miss_req,
    input  tag_t      miss_tag,
    // External bus
    input  logic      bus_rdy,
    input  bus_byte_t bus_rdata,
    output logic      bus_req,
    output bus_addr_t bus_addr,
    // Fetch side
    output logic      slot,
    output line_t     fill_line
);

    localparam beat_t LAST_BEAT = beat_t'(`LINE_BYTES - 1);
    localparam int    PART_W    = (`LINE_BYTES - 1) * `BYTE_W;

    //================================================
    // Beat counter
    //================================================
    logic      burst_act;
    beat_t     beat_cnt;
    logic      burst_start;
    logic      last_beat;
    tag_t      pend_tag;
    tag_t      sel_tag;
    bus_addr_t line_base;

    // First beat leaves together with the accepted miss
    assign burst_start = ~burst_act & miss_req & bus_rdy;
    assign last_beat   = burst_act & (beat_cnt == LAST_BEAT);

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            burst_act <= 1'b0;
        else if (burst_start)
            burst_act <= 1'b1;
        else if (last_beat & bus_rdy)
            burst_act <= 1'b0;
    end

    // Wraps back to zero after the last beat
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            beat_cnt <= '0;
        else if (bus_rdy & (burst_act | miss_req))
            beat_cnt <= beat_cnt + beat_t'(1);
    end

    always_ff @(posedge CLK)
    begin
        if (burst_start)
            pend_tag <= miss_tag;
    end

    //================================================
    // Bus address phase
    //================================================
    assign sel_tag   = burst_act ? pend_tag : miss_tag;
    // Instruction lines live in the lower half of the bus space
    assign line_base = {1'b0, sel_tag, {$bits(beat_t){1'b0}}};
    assign bus_addr  = line_base + bus_addr_t'(beat_cnt);
    assign bus_req   = burst_act | miss_req;

    //================================================
    // Line assembly
    //================================================
    logic [PART_W-1:0] part_line;

    // Beat n accepted means byte n-1 is on the bus
    always_ff @(posedge CLK)
    begin
        if (burst_act & bus_rdy)
            part_line[(int'(beat_cnt) - 1) * `BYTE_W +: `BYTE_W] <= bus_rdata;
    end

    // Last byte joins straight from the bus
    assign fill_line = {bus_rdata, part_line};

    // Fetch side advances only between bursts
    assign slot = ~burst_act & bus_rdy;

endmodule

`default_nettype wire

//--- logic/icache_line_store.sv
//================================================
// Line data register and code select for the
// fetch data phase
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_line_store
    import icache_pkg::*;
(
    input  logic    CLK,
    input  logic    RES,
    // Line written at the end of a miss
    input  logic    line_we,
    input  line_t   fill_line,
    // Data-phase state from the lookup stage
    input  logic    dphase_hit,
    input  logic    dphase_miss,
    input  offset_t dphase_offset,
    output code_t   if_code
);

    line_t line_q;

    // Line data, written as a miss completes
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            line_q <= '0;
        else if (line_we)
            line_q <= fill_line;
    end

    //================================================
    // Code select
    //================================================
    always_comb
    begin
        if (dphase_hit)
            if_code = line_q[dphase_offset * `CODE_W +: `CODE_W];
        // Miss returns its code as the line completes
        else if (dphase_miss)
            if_code = fill_line[dphase_offset * `CODE_W +: `CODE_W];
        else
            if_code = code_t'(`NOP_CODE);
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
//================================================
// Instruction-fetch cache top: lookup, burst fill
// and line store
//================================================

`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic        CLK,
    input  logic        RES,
    // CPU fetch port
    input  logic        if_req,
    input  fetch_addr_t if_addr,
    output code_t       if_code,
    output logic        if_rdy,
    // External bus
    input  logic        bus_rdy,
    input  bus_byte_t   bus_rdata,
    output logic        bus_req,
    output bus_addr_t   bus_addr
);

    logic    slot;
    logic    miss_req;
    tag_t    miss_tag;
    logic    dphase_hit;
    logic    dphase_miss;
    offset_t dphase_offset;
    logic    line_we;
    line_t   fill_line;

    // Fetch ready follows bus ready, hits included
    assign if_rdy = slot;

    icache_lookup u_lookup
    (
        .CLK           (CLK),
        .RES           (RES),
        .if_req        (if_req),
        .if_addr       (if_addr),
        .slot          (slot),
        .miss_req      (miss_req),
        .miss_tag      (miss_tag),
        .dphase_hit    (dphase_hit),
        .dphase_miss   (dphase_miss),
        .dphase_offset (dphase_offset),
        .line_we       (line_we)
    );

    bus_burst_fill u_fill
    (
        .CLK       (CLK),
        .RES       (RES),
        .miss_req  (miss_req),
        .miss_tag  (miss_tag),
        .bus_rdy   (bus_rdy),
        .bus_rdata (bus_rdata),
        .bus_req   (bus_req),
        .bus_addr  (bus_addr),
        .slot      (slot),
        .fill_line (fill_line)
    );

    icache_line_store u_store
    (
        .CLK           (CLK),
        .RES           (RES),
        .line_we       (line_we),
        .fill_line     (fill_line),
        .dphase_hit    (dphase_hit),
        .dphase_miss   (dphase_miss),
        .dphase_offset (dphase_offset),
        .if_code       (if_code)
    );

endmodule

`default_nettype wire

//--- dv/icache_assert.sv
//================================================
// Assertions on burst beats, fetch ready and the
// idle code, bound into the cache top
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_assert
    import icache_pkg::*;
(
    input  logic      CLK,
    input  logic      RES,
    input  logic      if_req,
    input  logic      if_rdy,
    input  code_t     if_code,
    input  logic      bus_req,
    input  logic      bus_rdy,
    input  bus_addr_t bus_addr
);

    int        fail_step = 0;
    int        fail_rdy = 0;
    int        fail_nop = 0;
    logic      mid_burst;
    bus_addr_t next_addr;
    logic      beat_acc;
    logic      dphase_open;

    assign beat_acc = bus_req & bus_rdy;

    // Beats remain until the byte at offset 3 is accepted
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            mid_burst <= 1'b0;
            next_addr <= '0;
        end
        else if (beat_acc)
        begin
            mid_burst <= (bus_addr[1:0] != 2'd3);
            next_addr <= bus_addr + bus_addr_t'(1);
        end
    end

    // Data phase opens at an accepted fetch and closes at the next ready edge
    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
            dphase_open <= 1'b0;
        else if (if_rdy)
            dphase_open <= if_req;
    end

    assert property (@(posedge CLK) disable iff (RES)
        (beat_acc && mid_burst) |-> (bus_addr == next_addr))
    else
    begin
        $error("bus_addr did not step by one within a burst");
        fail_step = fail_step + 1;
    end

    assert property (@(posedge CLK) disable iff (RES) mid_burst |-> !if_rdy)
    else
    begin
        $error("if_rdy rose while burst beats remained");
        fail_rdy = fail_rdy + 1;
    end

    assert property (@(posedge CLK) disable iff (RES)
        !dphase_open |-> (if_code == code_t'(`NOP_CODE)))
    else
    begin
        $error("if_code not NOP outside a data phase");
        fail_nop = fail_nop + 1;
    end

endmodule

bind icache_top icache_assert u_assert
(
    .CLK      (CLK),
    .RES      (RES),
    .if_req   (if_req),
    .if_rdy   (if_rdy),
    .if_code  (if_code),
    .bus_req  (bus_req),
    .bus_rdy  (bus_rdy),
    .bus_addr (bus_addr)
);

`default_nettype wire

//--- dv/icache_checker.sv
//================================================
// Fetch checker: reference model, compare process
// and error counts
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_checker
    import icache_pkg::*;
(
    input  logic        CLK,
    input  logic        RES,
    input  logic        if_req,
    input  fetch_addr_t if_addr,
    input  code_t       if_code,
    input  logic        if_rdy,
    input  logic        bus_req,
    input  bus_addr_t   bus_addr,
    input  logic        bus_rdy,
    input  int          exp_fetches,
    input  logic        run_done,
    output int          err_cnt,
    output int          acc_cnt,
    output int          done_cnt,
    output logic        end_done
);

    fetch_addr_t dph_q[$];
    bus_addr_t   beat_q[$];
    logic        dph_miss;
    int          rdy_seen;
    int          rdy_now;
    tag_t        ref_tag;
    logic        ref_valid;
    fetch_addr_t done_addr;
    code_t       exp_code;
    bus_addr_t   base;

    // Code at an even address is the low nibble of the byte at half of it
    function automatic code_t ref_code(input fetch_addr_t a);
        bus_byte_t b;
        b = icache_tb.mem[a >> 1];
        return a[0] ? b[7:4] : b[3:0];
    endfunction

    always @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            dph_q.delete();
            beat_q.delete();
            dph_miss  = 1'b0;
            rdy_seen  = 0;
            ref_valid = 1'b0;
            ref_tag   = '0;
            err_cnt   = 0;
            acc_cnt   = 0;
            done_cnt  = 0;
            end_done  = 1'b0;
        end
        else
        begin
            //================================================
            // Data phase end
            //================================================
            if (dph_q.size() != 0)
            begin
                rdy_now = rdy_seen + (bus_rdy ? 1 : 0);
                // A hit ends on its first ready edge, a miss after one per beat
                if (if_rdy !== (rdy_now == (dph_miss ? `LINE_BYTES : 1)))
                begin
                    $display("Fail %0t: if_rdy %b after %0d ready edges of a %s data phase",
                             $time, if_rdy, rdy_now, dph_miss ? "miss" : "hit");
                    err_cnt++;
                end
                rdy_seen = rdy_now;
                if (if_rdy)
                begin
                    done_addr = dph_q.pop_front();
                    exp_code  = ref_code(done_addr);
                    done_cnt++;
                    if (if_code !== exp_code)
                    begin
                        $display("Fail %0t: if_code %h at address %h, expected %h",
                                 $time, if_code, done_addr, exp_code);
                        err_cnt++;
                    end
                end
            end
            else if (if_code !== `NOP_CODE || if_rdy !== bus_rdy || (!if_req && bus_req))
            begin
                $display("Fail %0t: idle if_code %h, if_rdy %b, bus_rdy %b, bus_req %b",
                         $time, if_code, if_rdy, bus_rdy, bus_req);
                err_cnt++;
            end

            // Accepted fetch, single-entry reference cache
            if (if_req && if_rdy)
            begin
                dph_q.push_back(if_addr);
                acc_cnt++;
                rdy_seen = 0;
                dph_miss = !ref_valid || (ref_tag != if_addr[`FETCH_ADDR_W-1:3]);
                if (dph_miss)
                begin
                    base = {1'b0, if_addr[`FETCH_ADDR_W-1:3], 2'b00};
                    for (int j = 0; j < `LINE_BYTES; j++)
                        beat_q.push_back(base + bus_addr_t'(j));
                    ref_tag   = if_addr[`FETCH_ADDR_W-1:3];
                    ref_valid = 1'b1;
                end
            end

            // Accepted bus beat
            if (bus_req && bus_rdy)
            begin
                if (beat_q.size() == 0)
                begin
                    $display("Bus beat to %h issued while no line fill was due", bus_addr);
                    err_cnt++;
                end
                else
                begin
                    if (bus_addr !== beat_q[0])
                    begin
                        $display("Fail %0t: bus_addr %h, expected %h", $time, bus_addr, beat_q[0]);
                        err_cnt++;
                    end
                    void'(beat_q.pop_front());
                end
            end

            if (run_done && !end_done)
            begin
                if (dph_q.size() != 0 || done_cnt != acc_cnt || acc_cnt != exp_fetches)
                begin
                    $display("Fetch count mismatch: %0d issued, %0d accepted, %0d completed",
                             exp_fetches, acc_cnt, done_cnt);
                    err_cnt++;
                end
                if (beat_q.size() != 0)
                begin
                    $display("%0d bus beats of a line fill never went out", beat_q.size());
                    err_cnt++;
                end
                end_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
//================================================
// Testbench top: clock, reset, fetch stimulus,
// bus memory model and watchdog
//================================================

`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_tb
    import icache_pkg::*;
();

    logic        CLK = 1'b0;
    logic        RES;
    logic        if_req;
    fetch_addr_t if_addr;
    code_t       if_code;
    logic        if_rdy;
    logic        bus_rdy = 1'b1;
    bus_byte_t   bus_rdata = '0;
    logic        bus_req;
    bus_addr_t   bus_addr;

    // Bus memory, read by the checker too
    bus_byte_t   mem [0:(1 << `BUS_ADDR_W) - 1];
    logic        rdy_pat [0:1023];
    int          seed = 66;
    int          cyc = 0;
    logic        stall_en = 1'b0;
    fetch_addr_t fetch_q[$];
    logic        stall_q[$];
    int          n_fetch = 0;
    logic        run_done;
    int          err_cnt;
    int          acc_cnt;
    int          done_cnt;
    logic        end_done;
    int          assert_fails;

    always #10 CLK = ~CLK;

    icache_top uut
    (
        .CLK       (CLK),
        .RES       (RES),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_code   (if_code),
        .if_rdy    (if_rdy),
        .bus_rdy   (bus_rdy),
        .bus_rdata (bus_rdata),
        .bus_req   (bus_req),
        .bus_addr  (bus_addr)
    );

    icache_checker u_checker
    (
        .CLK         (CLK),
        .RES         (RES),
        .if_req      (if_req),
        .if_addr     (if_addr),
        .if_code     (if_code),
        .if_rdy      (if_rdy),
        .bus_req     (bus_req),
        .bus_addr    (bus_addr),
        .bus_rdy     (bus_rdy),
        .exp_fetches (n_fetch),
        .run_done    (run_done),
        .err_cnt     (err_cnt),
        .acc_cnt     (acc_cnt),
        .done_cnt    (done_cnt),
        .end_done    (end_done)
    );

    //================================================
    // Bus model
    //================================================
    // Byte of an accepted beat shows up in the next period
    always @(posedge CLK)
    begin
        if (bus_req && bus_rdy)
            bus_rdata <= mem[bus_addr];
        bus_rdy <= stall_en ? rdy_pat[cyc % 1024] : 1'b1;
        cyc <= cyc + 1;
    end

    task automatic init_random_data;
        for (int i = 0; i < (1 << `BUS_ADDR_W); i++)
            mem[i] = bus_byte_t'($random(seed));
        // Roughly one stall edge in four
        for (int i = 0; i < 1024; i++)
            rdy_pat[i] = (($random(seed) & 3) != 0);
    endtask

    task automatic push_fetch(input fetch_addr_t a, input logic stall);
        fetch_q.push_back(a);
        stall_q.push_back(stall);
    endtask

    task automatic build_fetch_list;
        fetch_addr_t a;
        // One miss then seven hits in the same line
        for (int i = 0; i < `LINE_CODES; i++)
            push_fetch(fetch_addr_t'(16'h0120 + i), 1'b0);
        // Other line, then back to the first one
        push_fetch(16'h0348, 1'b0);
        push_fetch(16'h034b, 1'b0);
        push_fetch(16'h0125, 1'b0);
        push_fetch(16'h0126, 1'b0);
        for (int i = 0; i < 40; i++)
            push_fetch(fetch_addr_t'(16'h0a00 + i), 1'b1);
        // Mixed run, mostly sequential with random jumps
        a = 16'hf3c0;
        for (int i = 0; i < 300; i++)
        begin
            if (($random(seed) & 3) == 0)
                a = fetch_addr_t'($random(seed));
            else
                a = a + 16'd1;
            push_fetch(a, 1'b1);
        end
    endtask

    task automatic wait_ready;
        @(posedge CLK);
        while (!if_rdy)
            @(posedge CLK);
    endtask

    // A new address goes out at every edge that accepts one
    task automatic run_fetches;
        if_req   <= 1'b1;
        if_addr  <= fetch_q[0];
        stall_en <= stall_q[0];
        for (int idx = 1; idx < n_fetch; idx++)
        begin
            wait_ready();
            if_addr  <= fetch_q[idx];
            stall_en <= stall_q[idx];
        end
        wait_ready();
        if_req <= 1'b0;
        wait_ready();
    endtask

    //================================================
    // Main sequence
    //================================================
    initial
    begin
        RES      = 1'b1;
        if_req   = 1'b0;
        if_addr  = '0;
        run_done = 1'b0;
        init_random_data();
        build_fetch_list();
        n_fetch = fetch_q.size();
        repeat (5) @(posedge CLK);
        RES <= 1'b0;
        // Idle period under random bus stalls
        stall_en <= 1'b1;
        repeat (12) @(posedge CLK);
        run_fetches();
        run_done <= 1'b1;
        wait (end_done);
        assert_fails = uut.u_assert.fail_step + uut.u_assert.fail_rdy
                       + uut.u_assert.fail_nop;
        $display("Done: %0d errors, %0d assertion failures, %0d fetches accepted, %0d completed",
                 err_cnt, assert_fails, acc_cnt, done_cnt);
        if (err_cnt == 0 && assert_fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (n_fetch > 0);
        #(n_fetch * 40 * 20);
        $display("Timeout: the fetch run did not finish within %0d cycles", n_fetch * 40);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_lookup.sv
logic/bus_burst_fill.sv
logic/icache_line_store.sv
logic/icache_top.sv
dv/icache_assert.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction-fetch cache testbench with Verilator
# Exit status is zero only when the run prints the pass line

verilator --binary --timing --assert --top-module icache_tb -f vlog.f \
    && ./obj_dir/Vicache_tb +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -qx "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
